//--- src/rename_arch_pkg.sv
// architectural register space seen by the rename core
// every index is renamed, the zero register included
package rename_arch_pkg;

  ////////////////////////////////////////
  // integer register file
  ////////////////////////////////////////

  // registers visible to software
  localparam int ARCH_REG_COUNT = 32;

  // index width, log2 of the count above
  localparam int ARCH_IDX_WIDTH = 5;

  ////////////////////////////////////////
  // reset mapping
  ////////////////////////////////////////

  // after reset arch register i lives in physical tag i,
  // so the first ARCH_REG_COUNT tags start out mapped and
  // the free list holds the tags from ARCH_REG_COUNT upward

endpackage

//--- src/rob_ctrl_pkg.sv
// retire controller state codes and default core sizes
// physical count must exceed the arch count by at least the ROB depth
package rob_ctrl_pkg;

  ////////////////////////////////////////
  // retire controller states
  ////////////////////////////////////////

  localparam int STATE_WIDTH = 2;

  // free list being loaded after reset
  localparam logic [STATE_WIDTH-1:0] STATE_FILL = 2'd0;
  // initial ROB credits handed out
  localparam logic [STATE_WIDTH-1:0] STATE_GRANT = 2'd1;
  // in-order retirement
  localparam logic [STATE_WIDTH-1:0] STATE_RUN = 2'd2;

  ////////////////////////////////////////
  // default sizes
  ////////////////////////////////////////

  // 32 arch + 16 spare tags
  localparam int DEFAULT_PHYS_REG_COUNT = 48;
  // power of two
  localparam int DEFAULT_ROB_DEPTH = 8;

endpackage

//--- src/map_table.sv
// speculative arch-to-physical map, identity after reset
// no checkpoints; a mapping only changes on dispatch
module map_table #(
  parameter int phys_reg_count = rob_ctrl_pkg::DEFAULT_PHYS_REG_COUNT
) (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       dispatch_valid,
  input  logic [rename_arch_pkg::ARCH_IDX_WIDTH-1:0] dispatch_arch,
  input  logic [$clog2(phys_reg_count)-1:0]          dispatch_tag,
  output logic [$clog2(phys_reg_count)-1:0]          old_tag
);
  import rename_arch_pkg::*;

  localparam int tag_width = $clog2(phys_reg_count);

  // one physical tag per arch register
  logic [tag_width-1:0] map [ARCH_REG_COUNT];

  ////////////////////////////////////////
  // lookup
  ////////////////////////////////////////

  // current mapping, read in the dispatch cycle
  // this becomes the old tag carried by the ROB entry
  assign old_tag = map[dispatch_arch];

  ////////////////////////////////////////
  // update
  ////////////////////////////////////////

  // reset loads the identity map
  // dispatch repoints the dest to the fresh tag at cycle end
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < ARCH_REG_COUNT; i++) begin
        map[i] <= tag_width'(i);
      end
    end else if (dispatch_valid) begin
      map[dispatch_arch] <= dispatch_tag;
    end
  end

  // same-register redispatch chains naturally:
  // next lookup returns the tag written here
  // retirement never touches this table

endmodule

//--- src/free_list.sv
// circular queue of free physical tags, loaded by a fill sequence after reset
// pop and push may share a cycle; capacity is phys_reg_count - ARCH_REG_COUNT
module free_list #(
  parameter int phys_reg_count = rob_ctrl_pkg::DEFAULT_PHYS_REG_COUNT
) (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              fill_en,
  input  logic                              pop,
  input  logic                              push,
  input  logic [$clog2(phys_reg_count)-1:0] push_tag,
  output logic [$clog2(phys_reg_count)-1:0] free_tag,
  output logic                              fill_done
);
  import rename_arch_pkg::*;

  localparam int tag_width = $clog2(phys_reg_count);
  localparam int depth = phys_reg_count - ARCH_REG_COUNT;
  localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
  localparam int count_width = $clog2(depth + 1);

  // tag storage
  logic [tag_width-1:0] ram [depth];

  logic [ptr_width-1:0]   head;
  logic [ptr_width-1:0]   tail;
  logic [count_width-1:0] count;
  logic [tag_width-1:0]   fill_value;
  logic [tag_width-1:0]   write_value;
  logic                   write;

  // wrap at depth, which need not be a power of two
  function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
    return (ptr == ptr_width'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////
  // write side
  ////////////////////////////////////////

  // fill slot k gets tag ARCH_REG_COUNT + k
  assign fill_value = tag_width'(ARCH_REG_COUNT) + tag_width'(tail);
  assign write = fill_en | push;
  assign write_value = fill_en ? fill_value : push_tag;

  // last fill write, queue full after this edge
  assign fill_done = fill_en & (count == count_width'(depth - 1));

  always_ff @(posedge clock) begin
    if (write) begin
      ram[tail] <= write_value;
    end
  end

  ////////////////////////////////////////
  // read side and pointers
  ////////////////////////////////////////

  // oldest free tag, valid whenever count is nonzero
  assign free_tag = ram[head];

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (pop) begin
        head <= next_ptr(head);
      end
      if (write) begin
        tail <= next_ptr(tail);
      end
      // simultaneous push and pop leaves count alone
      case ({write, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // credits must keep dispatch from draining the list
  a_pop_not_empty: assert property (
    @(posedge clock) disable iff (reset) pop |-> count != '0
  ) else $error("free list popped while empty");

  // retired tags can never exceed the spare count
  a_push_not_full: assert property (
    @(posedge clock) disable iff (reset) write |-> count != count_width'(depth)
  ) else $error("free list written while full");

endmodule

//--- src/rob_storage.sv
// reorder buffer entries with a tag CAM for completion
// rob_depth is a power of two, at least 2; tags in flight are unique
module rob_storage #(
  parameter int phys_reg_count = rob_ctrl_pkg::DEFAULT_PHYS_REG_COUNT,
  parameter int rob_depth = rob_ctrl_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       write,
  input  logic [$clog2(rob_depth)-1:0]               tail,
  input  logic [rename_arch_pkg::ARCH_IDX_WIDTH-1:0] write_arch,
  input  logic [$clog2(phys_reg_count)-1:0]          write_tag,
  input  logic [$clog2(phys_reg_count)-1:0]          write_old_tag,
  input  logic                                       complete_valid,
  input  logic [$clog2(phys_reg_count)-1:0]          complete_tag,
  input  logic                                       retire,
  input  logic [$clog2(rob_depth)-1:0]               head,
  output logic                                       head_done,
  output logic [rename_arch_pkg::ARCH_IDX_WIDTH-1:0] head_arch,
  output logic [$clog2(phys_reg_count)-1:0]          head_tag,
  output logic [$clog2(phys_reg_count)-1:0]          head_old_tag
);
  import rename_arch_pkg::*;

  localparam int tag_width = $clog2(phys_reg_count);

  // payload fields
  logic [ARCH_IDX_WIDTH-1:0] entry_arch    [rob_depth];
  logic [tag_width-1:0]      entry_tag     [rob_depth];
  logic [tag_width-1:0]      entry_old_tag [rob_depth];

  // control bits, one per entry
  logic [rob_depth-1:0] entry_valid;
  logic [rob_depth-1:0] entry_done;
  logic [rob_depth-1:0] tag_hit;

  ////////////////////////////////////////
  // completion match
  ////////////////////////////////////////

  // compare against every live entry
  always_comb begin
    for (int i = 0; i < rob_depth; i++) begin
      tag_hit[i] = complete_valid & entry_valid[i] & (entry_tag[i] == complete_tag);
    end
  end

  ////////////////////////////////////////
  // entry state
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      entry_done  <= '0;
    end else begin
      entry_done <= entry_done | tag_hit;
      if (retire) begin
        entry_valid[head] <= 1'b0;
      end
      // new entry starts not done
      if (write) begin
        entry_valid[tail] <= 1'b1;
        entry_done[tail]  <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (write) begin
      entry_arch[tail]    <= write_arch;
      entry_tag[tail]     <= write_tag;
      entry_old_tag[tail] <= write_old_tag;
    end
  end

  // head view, done only counts for a live entry
  assign head_done    = entry_valid[head] & entry_done[head];
  assign head_arch    = entry_arch[head];
  assign head_tag     = entry_tag[head];
  assign head_old_tag = entry_old_tag[head];

  // completion names exactly one in-flight entry still pending
  a_complete_one_open: assert property (
    @(posedge clock) disable iff (reset)
      complete_valid |-> $onehot(tag_hit) && ((tag_hit & entry_done) == '0)
  ) else $error("completion tag does not match one pending ROB entry");

endmodule

//--- src/rob_pointers.sv
// head, tail and occupancy of the reorder buffer
// rob_depth is a power of two so pointers wrap on overflow
module rob_pointers #(
  parameter int rob_depth = rob_ctrl_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic                         clock,
  input  logic                         reset,
  input  logic                         dispatch_valid,
  input  logic                         retire,
  output logic [$clog2(rob_depth)-1:0] head,
  output logic [$clog2(rob_depth)-1:0] tail,
  output logic                         empty
);

  localparam int count_width = $clog2(rob_depth + 1);

  // entries in flight
  logic [count_width-1:0] count;

  ////////////////////////////////////////
  // pointers
  ////////////////////////////////////////

  // tail moves on dispatch, head on retire
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (dispatch_valid) begin
        tail <= tail + 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // occupancy
  ////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      count <= '0;
    end else begin
      case ({dispatch_valid, retire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty = (count == '0);

  // credits alone must hold dispatch off a full ROB
  a_no_dispatch_full: assert property (
    @(posedge clock) disable iff (reset)
      dispatch_valid |-> count != count_width'(rob_depth)
  ) else $error("dispatch into a full ROB");

endmodule

//--- src/retire_control.sv
// start-up sequencing, initial credits and in-order retirement
// one retirement per cycle at most, each one returns a credit
module retire_control #(
  parameter int rob_depth = rob_ctrl_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic clock,
  input  logic reset,
  input  logic fill_done,
  input  logic empty,
  input  logic head_done,
  output logic fill_en,
  output logic retire,
  output logic credit_return,
  output logic retire_valid
);
  import rob_ctrl_pkg::*;

  localparam int grant_width = $clog2(rob_depth + 1);

  logic [STATE_WIDTH-1:0] state;
  logic [grant_width-1:0] grant_count;
  logic                   grant_last;

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // final credit of the grant burst
  assign grant_last = (grant_count == grant_width'(rob_depth - 1));

  // oldest entry leaves as soon as it is done
  assign retire = (state == STATE_RUN) & ~empty & head_done;
  assign retire_valid = retire;

  // one credit per grant cycle, then one per freed slot
  assign credit_return = (state == STATE_GRANT) | retire;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  // fill_en is held low for the cycle after reset,
  // then high until the free list reports its last write
  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= STATE_FILL;
      fill_en     <= 1'b0;
      grant_count <= '0;
    end else begin
      case (state)
        STATE_FILL: begin
          if (fill_done) begin
            fill_en <= 1'b0;
            state   <= STATE_GRANT;
          end else begin
            fill_en <= 1'b1;
          end
        end
        STATE_GRANT: begin
          // rob_depth consecutive credit cycles
          if (grant_last) begin
            state <= STATE_RUN;
          end else begin
            grant_count <= grant_count + 1'b1;
          end
        end
        STATE_RUN: begin
          // stays here until the next reset
          state <= STATE_RUN;
        end
        default: begin
          // unused code, restart the sequence
          state <= STATE_FILL;
        end
      endcase
    end
  end

endmodule

//--- src/rename_core.sv
// register-rename back end: map table, free list, ROB and retire control
// phys_reg_count >= 32 + rob_depth; dispatch is credit limited, no flush
module rename_core #(
  parameter int phys_reg_count = rob_ctrl_pkg::DEFAULT_PHYS_REG_COUNT,
  parameter int rob_depth = rob_ctrl_pkg::DEFAULT_ROB_DEPTH
) (
  input  logic                                       clock,
  input  logic                                       reset,
  input  logic                                       dispatch_valid,
  input  logic [rename_arch_pkg::ARCH_IDX_WIDTH-1:0] dispatch_arch,
  input  logic                                       complete_valid,
  input  logic [$clog2(phys_reg_count)-1:0]          complete_tag,
  output logic [$clog2(phys_reg_count)-1:0]          dispatch_tag,
  output logic [$clog2(phys_reg_count)-1:0]          dispatch_old_tag,
  output logic                                       credit_return,
  output logic                                       retire_valid,
  output logic [rename_arch_pkg::ARCH_IDX_WIDTH-1:0] retire_arch,
  output logic [$clog2(phys_reg_count)-1:0]          retire_tag,
  output logic [$clog2(phys_reg_count)-1:0]          retire_old_tag
);

  localparam int ptr_width = $clog2(rob_depth);

  // start-up handshake
  logic fill_en;
  logic fill_done;

  // ROB control
  logic                 retire;
  logic                 empty;
  logic                 head_done;
  logic [ptr_width-1:0] head;
  logic [ptr_width-1:0] tail;

  ////////////////////////////////////////
  // dispatch side
  ////////////////////////////////////////

  // old tag of the dest, read in the dispatch cycle
  map_table #(
    .phys_reg_count(phys_reg_count)
  ) map_table_i (
    .clock(clock),
    .reset(reset),
    .dispatch_valid(dispatch_valid),
    .dispatch_arch(dispatch_arch),
    .dispatch_tag(dispatch_tag),
    .old_tag(dispatch_old_tag)
  );

  // pops the new tag on dispatch, takes back the old tag on retire
  free_list #(
    .phys_reg_count(phys_reg_count)
  ) free_list_i (
    .clock(clock),
    .reset(reset),
    .fill_en(fill_en),
    .pop(dispatch_valid),
    .push(retire),
    .push_tag(retire_old_tag),
    .free_tag(dispatch_tag),
    .fill_done(fill_done)
  );

  ////////////////////////////////////////
  // reorder buffer
  ////////////////////////////////////////

  rob_storage #(
    .phys_reg_count(phys_reg_count),
    .rob_depth(rob_depth)
  ) rob_storage_i (
    .clock(clock),
    .reset(reset),
    .write(dispatch_valid),
    .tail(tail),
    .write_arch(dispatch_arch),
    .write_tag(dispatch_tag),
    .write_old_tag(dispatch_old_tag),
    .complete_valid(complete_valid),
    .complete_tag(complete_tag),
    .retire(retire),
    .head(head),
    .head_done(head_done),
    .head_arch(retire_arch),
    .head_tag(retire_tag),
    .head_old_tag(retire_old_tag)
  );

  rob_pointers #(
    .rob_depth(rob_depth)
  ) rob_pointers_i (
    .clock(clock),
    .reset(reset),
    .dispatch_valid(dispatch_valid),
    .retire(retire),
    .head(head),
    .tail(tail),
    .empty(empty)
  );

  // fill, grant, then retire in order
  retire_control #(
    .rob_depth(rob_depth)
  ) retire_control_i (
    .clock(clock),
    .reset(reset),
    .fill_done(fill_done),
    .empty(empty),
    .head_done(head_done),
    .fill_en(fill_en),
    .retire(retire),
    .credit_return(credit_return),
    .retire_valid(retire_valid)
  );

endmodule

//--- tb/clock_gen.sv
// testbench clock and synchronous reset source
// reset drops drive_delay after the last reset edge
module clock_gen #(
  parameter int period = 20,
  parameter int reset_cycles = 5,
  parameter int drive_delay = 2
) (
  output logic clock,
  output logic reset
);

  // free-running clock, first rising edge at half a period
  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  // reset held for a fixed number of rising edges
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    #drive_delay reset = 1'b0;
  end

endmodule

//--- tb/rename_core_tb.sv
// random dispatch and out-of-order completion against a reference rename model
// default sizes only; completions always name a pending in-flight entry
module rename_core_tb;
  import rename_arch_pkg::*;
  import rob_ctrl_pkg::*;

  localparam int phys_reg_count = DEFAULT_PHYS_REG_COUNT;
  localparam int rob_depth = DEFAULT_ROB_DEPTH;
  localparam int tag_width = $clog2(phys_reg_count);
  localparam int fill_length = phys_reg_count - ARCH_REG_COUNT;
  localparam int period = 20;
  localparam int reset_cycles = 5;
  localparam int drive_delay = 2;
  localparam int op_count = 2000;
  // cycles counted from the first edge with reset low
  // one idle cycle, then the fill, then the grant burst
  localparam int grant_first = fill_length + 1;
  localparam int run_first = grant_first + rob_depth;
  localparam int timeout_cycles = reset_cycles + run_first + op_count * 4;
  // dispatch windows with a fixed dest and with full-rate dispatch
  localparam int chain_first = 600;
  localparam int chain_last = 660;
  localparam int burst_first = 1200;
  localparam int burst_last = 1260;
  localparam logic [ARCH_IDX_WIDTH-1:0] chain_arch = 7;

  logic                      clock;
  logic                      reset;
  logic                      dispatch_valid;
  logic [ARCH_IDX_WIDTH-1:0] dispatch_arch;
  logic                      complete_valid;
  logic [tag_width-1:0]      complete_tag;
  logic [tag_width-1:0]      dispatch_tag;
  logic [tag_width-1:0]      dispatch_old_tag;
  logic                      credit_return;
  logic                      retire_valid;
  logic [ARCH_IDX_WIDTH-1:0] retire_arch;
  logic [tag_width-1:0]      retire_tag;
  logic [tag_width-1:0]      retire_old_tag;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  logic [tag_width-1:0]      model_map [ARCH_REG_COUNT];
  logic [tag_width-1:0]      model_free [$];
  // model ROB with the oldest entry at index 0
  logic [ARCH_IDX_WIDTH-1:0] rob_arch [$];
  logic [tag_width-1:0]      rob_tag [$];
  logic [tag_width-1:0]      rob_old_tag [$];
  bit                        rob_done [$];

  // expected outputs of the current cycle
  logic                      exp_credit;
  logic                      exp_retire;
  logic [ARCH_IDX_WIDTH-1:0] exp_retire_arch;
  logic [tag_width-1:0]      exp_retire_tag;
  logic [tag_width-1:0]      exp_retire_old_tag;
  logic [tag_width-1:0]      exp_dispatch_tag;
  logic [tag_width-1:0]      exp_old_tag;

  // dispatcher side bookkeeping
  int                        credits;
  int                        cycle_count;
  int                        max_occupancy;
  bit                        chain_seen;
  logic [tag_width-1:0]      chain_last_tag;
  logic [31:0]               lfsr_state;

  clock_gen #(
    .period(period),
    .reset_cycles(reset_cycles),
    .drive_delay(drive_delay)
  ) clock_gen_i (
    .clock(clock),
    .reset(reset)
  );

  rename_core #(
    .phys_reg_count(phys_reg_count),
    .rob_depth(rob_depth)
  ) dut_i (
    .clock(clock),
    .reset(reset),
    .dispatch_valid(dispatch_valid),
    .dispatch_arch(dispatch_arch),
    .complete_valid(complete_valid),
    .complete_tag(complete_tag),
    .dispatch_tag(dispatch_tag),
    .dispatch_old_tag(dispatch_old_tag),
    .credit_return(credit_return),
    .retire_valid(retire_valid),
    .retire_arch(retire_arch),
    .retire_tag(retire_tag),
    .retire_old_tag(retire_old_tag)
  );

  // galois LFSR stepped once per bit taken with msb first into the result
  function automatic int random_bits(input int count);
    int   value;
    logic out_bit;
    value = 0;
    for (int i = 0; i < count; i++) begin
      out_bit = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) begin
        lfsr_state = lfsr_state ^ 32'h80200003;
      end
      value = (value << 1) | int'(out_bit);
    end
    return value;
  endfunction

  // identity map, spare tags in ascending order, empty ROB
  function automatic void reset_reference();
    for (int i = 0; i < ARCH_REG_COUNT; i++) begin
      model_map[i] = tag_width'(i);
    end
    model_free.delete();
    for (int k = 0; k < fill_length; k++) begin
      model_free.push_back(tag_width'(ARCH_REG_COUNT + k));
    end
    rob_arch.delete();
    rob_tag.delete();
    rob_old_tag.delete();
    rob_done.delete();
    credits = 0;
    cycle_count = 0;
    max_occupancy = 0;
    chain_seen = 1'b0;
  endfunction

  // expected outputs for this cycle, then the state after its closing edge
  function automatic void reference_step();
    bit grant_phase;
    bit run_phase;
    grant_phase = (cycle_count >= grant_first) && (cycle_count < run_first);
    run_phase = cycle_count >= run_first;
    exp_retire = run_phase && (rob_tag.size() > 0) && rob_done[0];
    exp_credit = grant_phase || exp_retire;
    if (exp_retire) begin
      exp_retire_arch = rob_arch[0];
      exp_retire_tag = rob_tag[0];
      exp_retire_old_tag = rob_old_tag[0];
    end
    if (model_free.size() > 0) begin
      exp_dispatch_tag = model_free[0];
    end
    exp_old_tag = model_map[dispatch_arch];
    // completion marks the entry holding that tag
    if (complete_valid) begin
      for (int i = 0; i < rob_tag.size(); i++) begin
        if (rob_tag[i] == complete_tag) begin
          rob_done[i] = 1'b1;
        end
      end
    end
    // old tag goes to the back of the free FIFO
    if (exp_retire) begin
      model_free.push_back(rob_old_tag[0]);
      void'(rob_arch.pop_front());
      void'(rob_tag.pop_front());
      void'(rob_old_tag.pop_front());
      void'(rob_done.pop_front());
    end
    if (dispatch_valid) begin
      model_map[dispatch_arch] = exp_dispatch_tag;
      void'(model_free.pop_front());
      rob_arch.push_back(dispatch_arch);
      rob_tag.push_back(exp_dispatch_tag);
      rob_old_tag.push_back(exp_old_tag);
      rob_done.push_back(1'b0);
    end
  endfunction

  ////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////

  task automatic check_tag(input logic [tag_width-1:0] actual,
                           input logic [tag_width-1:0] expected,
                           input string what);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected tag %0d got %0d", $time, what, expected, actual);
      $display("test failed");
      $fatal(1, "physical tag mismatch");
    end
  endtask

  task automatic check_arch(input logic [ARCH_IDX_WIDTH-1:0] actual,
                            input logic [ARCH_IDX_WIDTH-1:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected reg %0d got %0d", $time, what, expected, actual);
      $display("test failed");
      $fatal(1, "architectural index mismatch");
    end
  endtask

  task automatic check_count(input int actual,
                             input int expected,
                             input string what);
    if (actual != expected) begin
      $display("FAILED at time %0t: %s expected %0d got %0d", $time, what, expected, actual);
      $display("test failed");
      $fatal(1, "count mismatch");
    end
  endtask

  task automatic check_flag(input logic actual,
                            input logic expected,
                            input string what);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %b got %b", $time, what, expected, actual);
      $display("test failed");
      $fatal(1, "control flag mismatch");
    end
  endtask

  ////////////////////////////////////////
  // compare process
  ////////////////////////////////////////

  // sampled mid-cycle once inputs and combinational outputs settle
  always @(negedge clock) begin
    if (!reset) begin
      reference_step();
      check_flag(credit_return, exp_credit, "credit_return");
      check_flag(retire_valid, exp_retire, "retire_valid");
      if (exp_retire) begin
        check_arch(retire_arch, exp_retire_arch, "retire_arch");
        check_tag(retire_tag, exp_retire_tag, "retire_tag");
        check_tag(retire_old_tag, exp_retire_old_tag, "retire_old_tag");
      end
      if (dispatch_valid) begin
        check_tag(dispatch_tag, exp_dispatch_tag, "dispatch_tag");
        check_tag(dispatch_old_tag, exp_old_tag, "dispatch_old_tag");
        // same dest renamed again gets the previous new tag as old tag
        if (dispatch_arch == chain_arch) begin
          if (chain_seen) begin
            check_tag(dispatch_old_tag, chain_last_tag, "chained old tag");
          end
          chain_seen = 1'b1;
          chain_last_tag = exp_dispatch_tag;
        end
      end
      credits = credits + int'(credit_return) - int'(dispatch_valid);
      if (rob_tag.size() > max_occupancy) begin
        max_occupancy = rob_tag.size();
      end
      cycle_count++;
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    int  ops;
    int  pick;
    int  pending [$];
    bit  in_chain;
    bit  in_burst;
    bit  want;
    dispatch_valid = 1'b0;
    dispatch_arch = '0;
    complete_valid = 1'b0;
    complete_tag = '0;
    lfsr_state = 32'h1c9121c2;
    reset_reference();
    ops = 0;
    wait (reset == 1'b0);
    while ((ops < op_count) || (rob_tag.size() > 0) || dispatch_valid) begin
      @(posedge clock);
      #drive_delay;
      in_chain = (ops >= chain_first) && (ops < chain_last);
      in_burst = (ops >= burst_first) && (ops < burst_last);
      // dispatch only while a credit is held
      dispatch_valid = 1'b0;
      if ((ops < op_count) && (credits > 0)) begin
        dispatch_valid = in_burst ? 1'b1 : (random_bits(2) != 0);
      end
      if (dispatch_valid) begin
        dispatch_arch = in_chain ? chain_arch : ARCH_IDX_WIDTH'(random_bits(ARCH_IDX_WIDTH));
        ops++;
      end
      // complete one random pending entry
      complete_valid = 1'b0;
      pending.delete();
      for (int i = 0; i < rob_tag.size(); i++) begin
        if (!rob_done[i]) begin
          pending.push_back(i);
        end
      end
      if (pending.size() > 0) begin
        // burst holds completions until the ROB is full
        want = in_burst ? (rob_tag.size() == rob_depth) : (random_bits(1) == 1);
        if (want) begin
          pick = pending[random_bits(3) % pending.size()];
          complete_valid = 1'b1;
          complete_tag = rob_tag[pick];
        end
      end
    end
    @(posedge clock);
    #drive_delay;
    dispatch_valid = 1'b0;
    complete_valid = 1'b0;
    repeat (2) @(posedge clock);
    check_count(max_occupancy, rob_depth, "peak ROB occupancy");
    $display("test passed");
    $finish;
  end

  // run length bound from the fill, grant and operation count
  initial begin
    #(timeout_cycles * period);
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- tb.f
src/rename_arch_pkg.sv
src/rob_ctrl_pkg.sv
src/map_table.sv
src/free_list.sv
src/rob_storage.sv
src/rob_pointers.sv
src/retire_control.sv
src/rename_core.sv
tb/clock_gen.sv
tb/rename_core_tb.sv
